/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation into sim.log and check it"
	@echo "  clean  remove the build output and the log"

test:
	verilator --binary --assert --top-module csr_unit_tb -f list.f -Mdir obj_dir
	./obj_dir/Vcsr_unit_tb | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/csr_counters.sv */
`timescale 1ns/1ns
`include "csr_params.svh"

module csr_counters (
    input  logic                clk,
    input  logic                arst_n,
    input  csr_pkg::csr_write_t wr,
    input  logic                instr_retired,
    input  logic [1:0]          count_inhibit,
    output logic [63:0]         mcycle,
    output logic [63:0]         minstret
);
    import csr_pkg::*;

    logic [63:0] mcycle_next;
    logic [63:0] minstret_next;

    // One counter step increments with carry and lets a write replace
    // either half on its own
    function automatic logic [63:0] count_step(input logic [63:0] cnt,
                                               input logic inc,
                                               input logic wr_lo,
                                               input logic wr_hi,
                                               input csr_write_t w);
        logic [32:0] lo_sum;
        logic [31:0] hi_val;
        lo_sum = {1'b0, cnt[31:0]} + {32'd0, inc};
        hi_val = cnt[63:32] + {31'd0, lo_sum[32]};
        if (wr_lo) begin
            lo_sum[31:0] = csr_apply(w.op, cnt[31:0], w.data);
        end
        if (wr_hi) begin
            hi_val = csr_apply(w.op, cnt[63:32], w.data);
        end
        return {hi_val, lo_sum[31:0]};
    endfunction

    // ========================================================================
    // Next values
    // ========================================================================
    assign mcycle_next   = count_step(mcycle, !count_inhibit[0],
                                      wr.en && (wr.addr == `CSR_MCYCLE),
                                      wr.en && (wr.addr == `CSR_MCYCLEH), wr);

    // Retire pulse only counts when instret is not inhibited
    assign minstret_next = count_step(minstret, instr_retired && !count_inhibit[1],
                                      wr.en && (wr.addr == `CSR_MINSTRET),
                                      wr.en && (wr.addr == `CSR_MINSTRETH), wr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= mcycle_next;
            minstret <= minstret_next;
        end
    end

endmodule

/* hdl/csr_decode.sv */
`timescale 1ns/1ns
`include "csr_params.svh"

module csr_decode (
    input  csr_pkg::csr_inst_t  inst,
    input  csr_pkg::csr_data_t  rs1_data,
    output csr_pkg::csr_write_t wr,
    output logic                illegal_access
);
    import csr_pkg::*;

    logic implemented;
    logic is_write;
    logic read_only;

    // ========================================================================
    // Address check against the implemented set
    // ========================================================================
    always_comb begin
        case (inst.addr)
            `CSR_MSTATUS, `CSR_MISA, `CSR_MIE, `CSR_MTVEC, `CSR_MCOUNTINHIBIT,
            `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_SCRATCH,
            `CSR_MCYCLE, `CSR_MCYCLEH, `CSR_MINSTRET, `CSR_MINSTRETH,
            `CSR_CYCLE, `CSR_CYCLEH, `CSR_INSTRET, `CSR_INSTRETH,
            `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID:
                implemented = 1'b1;
            default:
                implemented = 1'b0;
        endcase
    end

    // A wren with no operation does not touch any register
    assign is_write  = inst.wren && (inst.op != CSR_OP_NONE);

    // Top two address bits set means read-only
    assign read_only = &inst.addr[11:10];

    assign illegal_access = ((inst.rden || is_write) && !implemented)
                         || (is_write && read_only);

    // ========================================================================
    // Write request towards counters and register file
    // ========================================================================
    assign wr.en   = is_write && !illegal_access;
    assign wr.op   = inst.op;
    assign wr.addr = inst.addr;
    // Operand select
    assign wr.data = inst.imm_sel ? inst.imm : rs1_data;

endmodule

/* hdl/csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Machine-mode read-write registers
`define CSR_MSTATUS         12'h300
`define CSR_MISA            12'h301
`define CSR_MIE             12'h304
`define CSR_MTVEC           12'h305
`define CSR_MCOUNTINHIBIT   12'h320
`define CSR_MSCRATCH        12'h340
`define CSR_MEPC            12'h341
`define CSR_MCAUSE          12'h342
`define CSR_MTVAL           12'h343
// Custom scratch in the non-standard range
`define CSR_SCRATCH         12'h800

// Counters and their user-level read-only aliases
`define CSR_MCYCLE          12'hB00
`define CSR_MINSTRET        12'hB02
`define CSR_MCYCLEH         12'hB80
`define CSR_MINSTRETH       12'hB82
`define CSR_CYCLE           12'hC00
`define CSR_INSTRET         12'hC02
`define CSR_CYCLEH          12'hC80
`define CSR_INSTRETH        12'hC82

// Identity registers that all read as zero
`define CSR_MVENDORID       12'hF11
`define CSR_MARCHID         12'hF12
`define CSR_MIMPID          12'hF13
`define CSR_MHARTID         12'hF14

// Trap causes
`define CAUSE_ILLEGAL_INSTR 32'h0000_0002
`define CAUSE_BREAKPOINT    32'h0000_0003
`define CAUSE_MISALIGNED    32'h0000_0004
`define CAUSE_EXT_INTERRUPT 32'h8000_000B

// Reset and constant values
`define SCRATCH_RESET       32'h0000_1001
`define MISA_VALUE          32'h4000_0100

`endif

/* hdl/csr_pkg.sv */
package csr_pkg;

    typedef logic [31:0] csr_data_t;
    typedef logic [11:0] csr_addr_t;

    // Same encoding as the op field of the core's CSR instruction
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    typedef struct packed {
        logic      rden;
        logic      wren;
        csr_op_e   op;
        csr_addr_t addr;
        csr_data_t imm;
        logic      imm_sel;
    } csr_inst_t;

    typedef struct packed {
        logic illegal_instruction;
        logic misaligned_access;
        logic breakpoint;
        logic external_interrupt;
    } csr_hw_event_t;

    // Legal software write after decode
    typedef struct packed {
        logic      en;
        csr_op_e   op;
        csr_addr_t addr;
        csr_data_t data;
    } csr_write_t;

    typedef struct packed {
        csr_data_t mstatus;
        csr_data_t mie;
        csr_data_t mtvec;
        csr_data_t mcountinhibit;
        csr_data_t mscratch;
        csr_data_t mepc;
        csr_data_t mcause;
        csr_data_t mtval;
        csr_data_t scratch;
    } csr_regs_t;

    // Write, set or clear applied to one 32-bit register
    function automatic csr_data_t csr_apply(input csr_op_e op, input csr_data_t old_val,
                                            input csr_data_t data);
        case (op)
            CSR_OP_WRITE: return data;
            CSR_OP_SET:   return old_val | data;
            CSR_OP_CLEAR: return old_val & ~data;
            default:      return old_val;
        endcase
    endfunction

endpackage

/* hdl/csr_regfile.sv */
`timescale 1ns/1ns
`include "csr_params.svh"

module csr_regfile (
    input  logic                  clk,
    input  logic                  arst_n,
    input  csr_pkg::csr_data_t    pc,
    input  csr_pkg::csr_write_t   wr,
    input  logic                  illegal_access,
    input  csr_pkg::csr_hw_event_t hw_event,
    input  logic                  rden,
    input  csr_pkg::csr_addr_t    rd_addr,
    input  logic [63:0]           mcycle,
    input  logic [63:0]           minstret,
    output csr_pkg::csr_data_t    read_data,
    output csr_pkg::csr_data_t    mepc,
    output logic                  trap_taken,
    output csr_pkg::csr_data_t    trap_target,
    output logic [1:0]            count_inhibit
);
    import csr_pkg::*;

    csr_regs_t regs;
    csr_regs_t regs_next;
    csr_data_t trap_cause;

    // ========================================================================
    // Trap detection and cause priority
    // ========================================================================
    assign trap_taken = (|hw_event) || illegal_access;

    always_comb begin
        if (hw_event.external_interrupt) begin
            trap_cause = `CAUSE_EXT_INTERRUPT;
        end else if (hw_event.breakpoint) begin
            trap_cause = `CAUSE_BREAKPOINT;
        end else if (illegal_access) begin
            trap_cause = `CAUSE_ILLEGAL_INSTR;
        end else if (hw_event.misaligned_access) begin
            trap_cause = `CAUSE_MISALIGNED;
        end else begin
            // Illegal instruction, or no trap at all
            trap_cause = `CAUSE_ILLEGAL_INSTR;
        end
    end

    // Vector base with the mode bits masked off
    assign trap_target = {regs.mtvec[31:2], 2'b00};

    // ========================================================================
    // Software writes, then trap capture
    // ========================================================================
    always_comb begin
        regs_next = regs;
        if (wr.en) begin
            case (wr.addr)
                `CSR_MSTATUS:
                    regs_next.mstatus = csr_apply(wr.op, regs.mstatus, wr.data);
                `CSR_MIE:
                    regs_next.mie = csr_apply(wr.op, regs.mie, wr.data);
                `CSR_MTVEC:
                    regs_next.mtvec = csr_apply(wr.op, regs.mtvec, wr.data);
                `CSR_MCOUNTINHIBIT:
                    regs_next.mcountinhibit = csr_apply(wr.op, regs.mcountinhibit, wr.data);
                `CSR_MSCRATCH:
                    regs_next.mscratch = csr_apply(wr.op, regs.mscratch, wr.data);
                `CSR_MEPC:
                    regs_next.mepc = csr_apply(wr.op, regs.mepc, wr.data);
                `CSR_MCAUSE:
                    regs_next.mcause = csr_apply(wr.op, regs.mcause, wr.data);
                `CSR_MTVAL:
                    regs_next.mtval = csr_apply(wr.op, regs.mtval, wr.data);
                `CSR_SCRATCH:
                    regs_next.scratch = csr_apply(wr.op, regs.scratch, wr.data);
                default: begin
                    // Counters and constants live elsewhere
                end
            endcase
        end
        // Hardware update overrides a write in the same cycle
        if (trap_taken) begin
            regs_next.mepc   = pc;
            regs_next.mcause = trap_cause;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs         <= '0;
            regs.scratch <= `SCRATCH_RESET;
        end else begin
            regs <= regs_next;
        end
    end

    // ========================================================================
    // Combinational read
    // ========================================================================
    always_comb begin
        read_data = '0;
        if (rden && !illegal_access) begin
            case (rd_addr)
                `CSR_MSTATUS:       read_data = regs.mstatus;
                `CSR_MISA:          read_data = `MISA_VALUE;
                `CSR_MIE:           read_data = regs.mie;
                `CSR_MTVEC:         read_data = regs.mtvec;
                `CSR_MCOUNTINHIBIT: read_data = regs.mcountinhibit;
                `CSR_MSCRATCH:      read_data = regs.mscratch;
                `CSR_MEPC:          read_data = regs.mepc;
                `CSR_MCAUSE:        read_data = regs.mcause;
                `CSR_MTVAL:         read_data = regs.mtval;
                `CSR_SCRATCH:       read_data = regs.scratch;
                // cycle and instret alias the machine counters
                `CSR_MCYCLE,   `CSR_CYCLE:    read_data = mcycle[31:0];
                `CSR_MCYCLEH,  `CSR_CYCLEH:   read_data = mcycle[63:32];
                `CSR_MINSTRET, `CSR_INSTRET:  read_data = minstret[31:0];
                `CSR_MINSTRETH, `CSR_INSTRETH: read_data = minstret[63:32];
                `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID:
                    read_data = '0;
                default:            read_data = '0;
            endcase
        end
    end

    assign mepc = regs.mepc;

    // Bit 0 inhibits mcycle, bit 2 inhibits minstret
    assign count_inhibit = {regs.mcountinhibit[2], regs.mcountinhibit[0]};

endmodule

/* hdl/csr_unit.sv */
`timescale 1ns/1ns

module csr_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  csr_pkg::csr_data_t     pc,
    input  csr_pkg::csr_inst_t     inst,
    input  csr_pkg::csr_data_t     rs1_data,
    input  csr_pkg::csr_hw_event_t hw_event,
    input  logic                   instr_retired,
    output csr_pkg::csr_data_t     read_data,
    output csr_pkg::csr_data_t     mepc,
    output logic                   trap_taken,
    output csr_pkg::csr_data_t     trap_target
);
    import csr_pkg::*;

    csr_write_t  wr;
    logic        illegal_access;
    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic [1:0]  count_inhibit;

    // Instruction split and access check
    csr_decode u_decode (
        .inst           (inst),
        .rs1_data       (rs1_data),
        .wr             (wr),
        .illegal_access (illegal_access)
    );

    csr_counters u_counters (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr            (wr),
        .instr_retired (instr_retired),
        .count_inhibit (count_inhibit),
        .mcycle        (mcycle),
        .minstret      (minstret)
    );

    // Registers, traps and the read path
    csr_regfile u_regfile (
        .clk            (clk),
        .arst_n         (arst_n),
        .pc             (pc),
        .wr             (wr),
        .illegal_access (illegal_access),
        .hw_event       (hw_event),
        .rden           (inst.rden),
        .rd_addr        (inst.addr),
        .mcycle         (mcycle),
        .minstret       (minstret),
        .read_data      (read_data),
        .mepc           (mepc),
        .trap_taken     (trap_taken),
        .trap_target    (trap_target),
        .count_inhibit  (count_inhibit)
    );

endmodule

/* list.f */
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_counters.sv
hdl/csr_regfile.sv
hdl/csr_unit.sv
sim/tb_clock.sv
sim/csr_unit_tb.sv

/* sim/csr_unit_tb.sv */
`timescale 1ns/1ns
`include "csr_params.svh"

module csr_unit_tb;
    import csr_pkg::*;

    // Reset, reset reads, read-write sweep, counters, illegal access, hardware traps
    localparam int TEST_CYCLES = 10 + 20 + 108 + 70 + 12 + 40;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic          clk;
    logic          arst_n;
    csr_data_t     pc;
    csr_inst_t     inst;
    csr_data_t     rs1_data;
    csr_hw_event_t hw_event;
    logic          instr_retired;
    csr_data_t     read_data;
    csr_data_t     mepc;
    logic          trap_taken;
    csr_data_t     trap_target;

    logic [31:0] lfsr = 32'hbfb8_decc;
    csr_data_t   shadow [csr_addr_t];
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;

    csr_addr_t rw_list [9] = '{`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MCOUNTINHIBIT,
                               `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_SCRATCH};
    csr_addr_t const_list [5] = '{`CSR_MISA, `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID,
                                  `CSR_MHARTID};

    tb_clock u_clock (.clk(clk));

    csr_unit dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .pc            (pc),
        .inst          (inst),
        .rs1_data      (rs1_data),
        .hw_event      (hw_event),
        .instr_retired (instr_retired),
        .read_data     (read_data),
        .mepc          (mepc),
        .trap_taken    (trap_taken),
        .trap_target   (trap_target)
    );

    // ========================================================================
    // Checks
    // ========================================================================
    task automatic check_value(input string name, input csr_data_t got, input csr_data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Any hardware event raises the trap output in the same cycle
    hw_event_trap: assert property (@(negedge clk) disable iff (!arst_n)
                                    (|hw_event) |-> trap_taken)
        else begin
            errors++;
            $display("Error at %0t ns: trap_taken = %b, expected 1", $time, trap_taken);
        end

    // ========================================================================
    // Random source and reference model
    // ========================================================================
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic is_counter(input csr_addr_t addr);
        return addr inside {`CSR_MCYCLE, `CSR_MCYCLEH, `CSR_MINSTRET, `CSR_MINSTRETH,
                            `CSR_CYCLE, `CSR_CYCLEH, `CSR_INSTRET, `CSR_INSTRETH};
    endfunction

    function automatic logic implemented(input csr_addr_t addr);
        return shadow.exists(addr) || is_counter(addr) ||
               (addr inside {`CSR_MISA, `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID,
                             `CSR_MHARTID});
    endfunction

    function automatic csr_data_t model_read(input csr_addr_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return (addr == `CSR_MISA) ? `MISA_VALUE : 32'h0;
    endfunction

    // Highest priority first
    function automatic csr_data_t expected_cause(input csr_hw_event_t ev, input logic illegal);
        if (ev.external_interrupt) return `CAUSE_EXT_INTERRUPT;
        if (ev.breakpoint) return `CAUSE_BREAKPOINT;
        if (illegal) return `CAUSE_ILLEGAL_INSTR;
        if (ev.misaligned_access) return `CAUSE_MISALIGNED;
        return `CAUSE_ILLEGAL_INSTR;
    endfunction

    // ========================================================================
    // One instruction per cycle checked at the falling edge
    // ========================================================================
    task automatic issue(input logic rd, input logic wen, input csr_op_e op,
                         input csr_addr_t addr, input csr_data_t data, input logic use_imm,
                         input csr_hw_event_t ev, input logic ret, output csr_data_t got);
        csr_inst_t i;
        csr_data_t pc_val;
        logic      is_wr;
        logic      illegal;
        logic      trap;
        i.rden    = rd;
        i.wren    = wen;
        i.op      = op;
        i.addr    = addr;
        // The unused operand carries the inverse so a wrong select shows up
        i.imm     = use_imm ? data : ~data;
        i.imm_sel = use_imm;
        pc_val    = rand_bits(30) << 2;
        @(posedge clk);
        inst          <= i;
        rs1_data      <= use_imm ? ~data : data;
        hw_event      <= ev;
        instr_retired <= ret;
        pc            <= pc_val;
        @(negedge clk);
        is_wr   = wen && (op != CSR_OP_NONE);
        illegal = ((rd || is_wr) && !implemented(addr)) || (is_wr && (&addr[11:10]));
        trap    = (|ev) || illegal;
        got     = read_data;
        check_value("trap_taken", 32'(trap_taken), 32'(trap));
        check_value("mepc", mepc, shadow[`CSR_MEPC]);
        if (trap) begin
            check_value("trap_target", trap_target, {shadow[`CSR_MTVEC][31:2], 2'b00});
        end
        if (!(rd && !illegal && is_counter(addr))) begin
            check_value("read_data", read_data, (rd && !illegal) ? model_read(addr) : 32'h0);
        end
        if (is_wr && !illegal && shadow.exists(addr)) begin
            case (op)
                CSR_OP_WRITE: shadow[addr] = data;
                CSR_OP_SET:   shadow[addr] = shadow[addr] | data;
                default:      shadow[addr] = shadow[addr] & ~data;
            endcase
        end
        if (trap) begin
            shadow[`CSR_MEPC]   = pc_val;
            shadow[`CSR_MCAUSE] = expected_cause(ev, illegal);
        end
    endtask

    task automatic read_csr(input csr_addr_t addr, output csr_data_t got);
        issue(1'b1, 1'b0, CSR_OP_NONE, addr, '0, 1'b0, '0, 1'b0, got);
    endtask

    task automatic write_csr(input csr_op_e op, input csr_addr_t addr, input csr_data_t data,
                             input logic use_imm);
        csr_data_t dummy;
        issue(1'b0, 1'b1, op, addr, data, use_imm, '0, 1'b0, dummy);
    endtask

    task automatic idle_cycles(input int n, input logic ret);
        csr_data_t dummy;
        repeat (n) issue(1'b0, 1'b0, CSR_OP_NONE, '0, '0, 1'b0, '0, ret, dummy);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        csr_data_t     c0;
        csr_data_t     c1;
        csr_data_t     bits;
        csr_data_t     pulses;
        csr_hw_event_t ev;
        int            k;
        int            m;
        arst_n        = 1'b0;
        pc            = '0;
        inst          = '0;
        rs1_data      = '0;
        hw_event      = '0;
        instr_retired = 1'b0;
        foreach (rw_list[j]) shadow[rw_list[j]] = '0;
        shadow[`CSR_SCRATCH] = `SCRATCH_RESET;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        // Reset values
        foreach (rw_list[j]) read_csr(rw_list[j], c1);
        foreach (const_list[j]) read_csr(const_list[j], c1);
        read_csr(`CSR_MINSTRET, c1);
        check_value("minstret", c1, 32'h0);
        read_csr(`CSR_MINSTRETH, c1);
        check_value("minstreth", c1, 32'h0);
        read_csr(`CSR_MCYCLEH, c1);
        check_value("mcycleh", c1, 32'h0);

        // Write, set and clear with both operands
        foreach (rw_list[j]) begin
            for (m = 0; m < 2; m++) begin
                write_csr(CSR_OP_WRITE, rw_list[j], rand_bits(32), m[0]);
                read_csr(rw_list[j], c1);
                write_csr(CSR_OP_SET, rw_list[j], rand_bits(32), m[0]);
                read_csr(rw_list[j], c1);
                write_csr(CSR_OP_CLEAR, rw_list[j], rand_bits(32), m[0]);
                read_csr(rw_list[j], c1);
            end
        end

        // Free-running cycle count, then inhibit
        write_csr(CSR_OP_WRITE, `CSR_MCOUNTINHIBIT, 32'h0, 1'b1);
        read_csr(`CSR_MCYCLE, c0);
        idle_cycles(24, 1'b0);
        read_csr(`CSR_MCYCLE, c1);
        check_value("mcycle", c1, c0 + 32'd25);
        read_csr(`CSR_CYCLE, c1);
        check_value("cycle", c1, c0 + 32'd26);
        write_csr(CSR_OP_SET, `CSR_MCOUNTINHIBIT, 32'h1, 1'b0);
        read_csr(`CSR_MCYCLE, c0);
        idle_cycles(5, 1'b0);
        read_csr(`CSR_MCYCLE, c1);
        check_value("mcycle", c1, c0);

        // Random retire pulses
        read_csr(`CSR_MINSTRET, c0);
        pulses = '0;
        for (k = 0; k < 20; k++) begin
            bits = rand_bits(1);
            idle_cycles(1, bits[0]);
            pulses = pulses + {31'd0, bits[0]};
        end
        read_csr(`CSR_MINSTRET, c1);
        check_value("minstret", c1, c0 + pulses);
        read_csr(`CSR_INSTRET, c0);
        check_value("instret", c0, c1);

        // Low half wraps into the high half
        write_csr(CSR_OP_CLEAR, `CSR_MCOUNTINHIBIT, 32'h1, 1'b1);
        write_csr(CSR_OP_WRITE, `CSR_MCYCLEH, 32'h7, 1'b1);
        write_csr(CSR_OP_WRITE, `CSR_MCYCLE, 32'hFFFF_FFFF, 1'b0);
        idle_cycles(1, 1'b0);
        read_csr(`CSR_MCYCLEH, c1);
        check_value("mcycleh", c1, 32'h8);
        read_csr(`CSR_MCYCLE, c1);
        check_value("mcycle", c1, 32'h1);
        read_csr(`CSR_CYCLEH, c1);
        check_value("cycleh", c1, 32'h8);

        // Illegal accesses
        write_csr(CSR_OP_SET, `CSR_MCOUNTINHIBIT, 32'h1, 1'b1);
        read_csr(`CSR_CYCLE, c0);
        write_csr(CSR_OP_WRITE, `CSR_CYCLE, rand_bits(32), 1'b0);
        read_csr(`CSR_MCAUSE, c1);
        check_value("mcause", c1, `CAUSE_ILLEGAL_INSTR);
        read_csr(`CSR_CYCLE, c1);
        check_value("cycle", c1, c0);
        write_csr(CSR_OP_WRITE, `CSR_MVENDORID, rand_bits(32), 1'b1);
        read_csr(`CSR_MVENDORID, c1);
        read_csr(12'h7C0, c1);
        write_csr(CSR_OP_SET, 12'h123, rand_bits(32), 1'b0);
        read_csr(`CSR_MEPC, c1);

        // Hardware events alone and combined
        write_csr(CSR_OP_WRITE, `CSR_MTVEC, rand_bits(32) | 32'h3, 1'b0);
        for (k = 0; k < 16; k++) begin
            bits = rand_bits(4);
            if (bits[3:0] == 4'h0) begin
                bits = 32'h1;
            end
            issue(1'b0, 1'b0, CSR_OP_NONE, '0, '0, 1'b0, bits[3:0], 1'b0, c1);
            read_csr(`CSR_MCAUSE, c1);
        end
        ev = '0;
        ev.breakpoint = 1'b1;
        issue(1'b0, 1'b1, CSR_OP_WRITE, `CSR_MCAUSE, rand_bits(32), 1'b1, ev, 1'b0, c1);
        read_csr(`CSR_MCAUSE, c1);
        check_value("mcause", c1, `CAUSE_BREAKPOINT);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule
